// ==== files.f ====
design/clint_pkg.sv
design/clint_reg_port.sv
design/clint_mtime.sv
design/clint_slice.sv
design/clint_top.sv
bench/clint_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CLINT testbench with Verilator, runs it and checks the log for the pass line

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=clint_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module clint_tb \
  -f files.f \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see $LOG_FILE"
exit 1

// ==== bench/clint_tb.sv ====
// Testbench for the CLINT top level with clocks, reset, a stimulus table, command driver and checks
`timescale 1ns/1ps

module clint_tb;

  typedef enum logic [2:0]
  {
    e_cmp_exact,
    e_cmp_zero,
    e_cmp_gt_prev,
    e_cmp_eq_prev,
    e_cmp_any,
    e_cmp_reach
  } cmp_e;

  // In each table row irq holds a check mask in the upper nibble and levels in the lower
  // Irq bit order is software, timer, machine external, supervisor external
  typedef struct packed
  {
    logic                                      wr;
    logic [clint_pkg::dev_addr_width-1:0]      addr;
    logic [clint_pkg::dword_width-1:0]         wdata;
    logic [clint_pkg::dword_width-1:0]         exp_data;
    cmp_e                                      mode;
    logic [7:0]                                irq;
    logic                                      rel;
    logic [7:0]                                gap;
  } entry_s;

  logic                                      clk_i;
  logic                                      rt_clk_i;
  logic                                      rst_n_i;
  clint_pkg::mem_header_s                    mem_cmd_header_i;
  logic [clint_pkg::dword_width-1:0]         mem_cmd_data_i;
  logic                                      mem_cmd_v_i;
  logic                                      mem_cmd_ready_and_o;
  clint_pkg::mem_header_s                    mem_resp_header_o;
  logic [clint_pkg::dword_width-1:0]         mem_resp_data_o;
  logic                                      mem_resp_v_o;
  logic                                      mem_resp_ready_and_i;
  logic                                      software_irq_o;
  logic                                      timer_irq_o;
  logic                                      m_external_irq_o;
  logic                                      s_external_irq_o;

  entry_s                                    table_q[$];
  logic [31:0]                               lfsr_state;
  int                                        err_count;
  int                                        fail_count;
  int                                        cycle_count;
  int                                        cycle_limit;
  int                                        cmd_count;
  int                                        resp_count;
  int                                        issued_count;

  clint_top u_dut
    (
      .clk_i                (clk_i),
      .rt_clk_i             (rt_clk_i),
      .rst_n_i              (rst_n_i),
      .mem_cmd_header_i     (mem_cmd_header_i),
      .mem_cmd_data_i       (mem_cmd_data_i),
      .mem_cmd_v_i          (mem_cmd_v_i),
      .mem_cmd_ready_and_o  (mem_cmd_ready_and_o),
      .mem_resp_header_o    (mem_resp_header_o),
      .mem_resp_data_o      (mem_resp_data_o),
      .mem_resp_v_o         (mem_resp_v_o),
      .mem_resp_ready_and_i (mem_resp_ready_and_i),
      .software_irq_o       (software_irq_o),
      .timer_irq_o          (timer_irq_o),
      .m_external_irq_o     (m_external_irq_o),
      .s_external_irq_o     (s_external_irq_o)
    );

  always #5 clk_i = ~clk_i;

  // The real-time clock is unrelated to clk_i
  always #17 rt_clk_i = ~rt_clk_i;

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Random response back-pressure takes one LFSR bit per cycle
  always @(posedge clk_i)
  begin
    #1;
    lfsr_state = lfsr_step(lfsr_state);
    mem_resp_ready_and_i = lfsr_state[0];
  end

  // The handshake monitor samples mid-cycle where all signals are stable
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (mem_resp_v_o && mem_cmd_ready_and_o)
        report_mismatch("command ready is high while a response is held");
      if (mem_cmd_v_i && mem_cmd_ready_and_o)
        cmd_count++;
      if (mem_resp_v_o && mem_resp_ready_and_i)
        resp_count++;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic add_entry(input logic wr, input logic [15:0] addr, input logic [63:0] wdata,
                           input logic [63:0] exp_data, input cmp_e mode, input logic [7:0] irq,
                           input logic rel = 1'b0, input logic [7:0] gap = 8'd0);
    entry_s e;
    e = '{wr: wr, addr: addr, wdata: wdata, exp_data: exp_data, mode: mode, irq: irq,
          rel: rel, gap: gap};
    table_q.push_back(e);
  endtask

  // Drives one command, waits for its response and checks the header echo
  task automatic run_cmd(input clint_pkg::mem_header_s hdr, input logic [63:0] wdata,
                         output logic [63:0] rdata);
    @(posedge clk_i);
    #1;
    mem_cmd_header_i = hdr;
    mem_cmd_data_i   = wdata;
    mem_cmd_v_i      = 1'b1;
    issued_count++;
    @(negedge clk_i);
    while (!mem_cmd_ready_and_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    mem_cmd_v_i = 1'b0;
    @(negedge clk_i);
    while (!(mem_resp_v_o && mem_resp_ready_and_i))
      @(negedge clk_i);
    rdata = mem_resp_data_o;
    if (mem_resp_header_o != hdr)
      report_mismatch($sformatf("response header %h, expected %h", mem_resp_header_o, hdr));
  endtask

  task automatic build_table();
    // Register read back, masking and unmapped addresses
    add_entry(1'b0, clint_pkg::msip_addr, '0, '0, e_cmp_exact, 8'hf4);
    add_entry(1'b1, clint_pkg::mtimecmp_addr, '1, '0, e_cmp_zero, 8'h40);
    add_entry(1'b0, clint_pkg::mtimecmp_addr, '0, '1, e_cmp_exact, 8'h40);
    add_entry(1'b1, clint_pkg::msip_addr, '1, '0, e_cmp_zero, 8'h88);
    add_entry(1'b0, clint_pkg::msip_addr, '0, 64'd1, e_cmp_exact, 8'h88);
    add_entry(1'b1, clint_pkg::msip_addr, 64'h2, '0, e_cmp_zero, 8'h80);
    add_entry(1'b0, clint_pkg::msip_addr, '0, '0, e_cmp_exact, 8'h80);
    add_entry(1'b1, clint_pkg::mtimesel_addr, 64'hfff0, '0, e_cmp_zero, 8'h00);
    add_entry(1'b0, clint_pkg::mtimesel_addr, '0, '0, e_cmp_exact, 8'h00);
    add_entry(1'b1, clint_pkg::plic_addr, 64'h1, '0, e_cmp_zero, 8'h32);
    add_entry(1'b0, clint_pkg::plic_addr, '0, 64'd1, e_cmp_exact, 8'h32);
    add_entry(1'b0, clint_pkg::plic_addr + 16'h4, '0, '0, e_cmp_exact, 8'h32);
    add_entry(1'b1, clint_pkg::plic_addr + 16'h4, 64'h3, '0, e_cmp_zero, 8'h33);
    add_entry(1'b0, clint_pkg::plic_addr + 16'h4, '0, 64'd1, e_cmp_exact, 8'h33);
    add_entry(1'b1, clint_pkg::plic_addr, 64'h0, '0, e_cmp_zero, 8'h31);
    add_entry(1'b0, clint_pkg::plic_addr, '0, '0, e_cmp_exact, 8'h31);
    add_entry(1'b1, 16'h1234, '1, '0, e_cmp_zero, 8'hb1);
    add_entry(1'b0, 16'h1234, '0, '0, e_cmp_zero, 8'hb1);
    add_entry(1'b0, clint_pkg::msip_addr, '0, '0, e_cmp_exact, 8'hb1);
    add_entry(1'b0, clint_pkg::mtimecmp_addr, '0, '1, e_cmp_exact, 8'h00);
    // Timer compare against a moving mtime
    add_entry(1'b1, clint_pkg::mtimecmp_addr, '0, '0, e_cmp_zero, 8'h44);
    add_entry(1'b0, clint_pkg::mtimecmp_addr, '0, '0, e_cmp_exact, 8'h44);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_any, 8'h00);
    add_entry(1'b1, clint_pkg::mtimecmp_addr, 64'd1000, '0, e_cmp_zero, 8'h40, 1'b1);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_reach, 8'h44);
    // Source select and ignored mtime writes
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_gt_prev, 8'h00);
    add_entry(1'b1, clint_pkg::mtime_addr, '0, '0, e_cmp_zero, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_gt_prev, 8'h00);
    add_entry(1'b1, clint_pkg::mtimesel_addr, 64'd3, '0, e_cmp_zero, 8'h00);
    add_entry(1'b0, clint_pkg::mtimesel_addr, '0, 64'd3, e_cmp_exact, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_any, 8'h00, 1'b0, 8'd4);
    add_entry(1'b0, clint_pkg::msip_addr, '0, '0, e_cmp_exact, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_eq_prev, 8'h00, 1'b0, 8'd10);
    add_entry(1'b1, clint_pkg::mtimesel_addr, 64'd1, '0, e_cmp_zero, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_any, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_gt_prev, 8'h00, 1'b0, 8'd20);
    // Going through the stopped select keeps the rt_clk_i switch free of double edges
    add_entry(1'b1, clint_pkg::mtimesel_addr, 64'd3, '0, e_cmp_zero, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_any, 8'h00, 1'b0, 8'd4);
    add_entry(1'b1, clint_pkg::mtimesel_addr, 64'd2, '0, e_cmp_zero, 8'h00);
    add_entry(1'b0, clint_pkg::mtime_addr, '0, '0, e_cmp_gt_prev, 8'h00, 1'b0, 8'd20);
    add_entry(1'b0, clint_pkg::mtimesel_addr, '0, 64'd2, e_cmp_exact, 8'h00);
  endtask

  initial
  begin
    entry_s                            e;
    clint_pkg::mem_header_s            hdr;
    logic [clint_pkg::dword_width-1:0] wdata;
    logic [clint_pkg::dword_width-1:0] rdata;
    logic [clint_pkg::dword_width-1:0] last_mtime;
    logic [clint_pkg::dword_width-1:0] cmp_target;
    logic [3:0]                        irq_now;
    logic                              ok;
    int                                errs_before;

    clk_i                = 1'b0;
    rt_clk_i             = 1'b0;
    rst_n_i              = 1'b0;
    mem_cmd_header_i     = '0;
    mem_cmd_data_i       = '0;
    mem_cmd_v_i          = 1'b0;
    mem_resp_ready_and_i = 1'b0;
    lfsr_state           = 32'h0c5217b9;
    err_count            = 0;
    fail_count           = 0;
    cycle_count          = 0;
    cmd_count            = 0;
    resp_count           = 0;
    issued_count         = 0;
    last_mtime           = '0;
    cmp_target           = '0;

    build_table();
    cycle_limit = table_q.size() * 200 + 10;

    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if (mem_resp_v_o || !mem_cmd_ready_and_o)
    begin
      $display("Error: the response port is not idle after reset");
      err_count++;
    end

    for (int i = 0; i < table_q.size(); i++)
    begin
      e = table_q[i];
      errs_before = err_count;
      repeat (e.gap) @(posedge clk_i);
      hdr.msg_type = e.wr ? clint_pkg::e_mem_wr : clint_pkg::e_mem_rd;
      hdr.size     = 3'd3;
      hdr.addr     = e.addr;
      wdata        = e.rel ? last_mtime + e.wdata : e.wdata;
      if (e.rel)
        cmp_target = wdata;
      run_cmd(hdr, wdata, rdata);
      // Poll until mtime has caught up with the compare value
      if (e.mode == e_cmp_reach)
        while (rdata < cmp_target)
          run_cmd(hdr, wdata, rdata);
      case (e.mode)
        e_cmp_exact:   ok = (rdata == e.exp_data);
        e_cmp_zero:    ok = (rdata == '0);
        e_cmp_gt_prev: ok = (rdata > last_mtime);
        e_cmp_eq_prev: ok = (rdata == last_mtime);
        default:       ok = 1'b1;
      endcase
      if (!ok)
        report_mismatch($sformatf("addr %h read %h, expected %h (mode %0d, previous %h)",
                                  e.addr, rdata, e.exp_data, e.mode, last_mtime));
      irq_now = {software_irq_o, timer_irq_o, m_external_irq_o, s_external_irq_o};
      if ((irq_now & e.irq[7:4]) != (e.irq[3:0] & e.irq[7:4]))
        report_mismatch($sformatf("irq levels %b, expected %b under mask %b",
                                  irq_now, e.irq[3:0], e.irq[7:4]));
      if (!e.wr && e.addr == clint_pkg::mtime_addr)
        last_mtime = rdata;
      if (err_count != errs_before)
        fail_count++;
      $display("Test %0d %s addr %h: %s", i, e.wr ? "write" : "read", e.addr,
               (err_count == errs_before) ? "ok" : "failed");
    end

    @(posedge clk_i);
    if (cmd_count != resp_count || cmd_count != issued_count)
    begin
      $display("Error: %0d commands issued, %0d accepted, %0d responses",
               issued_count, cmd_count, resp_count);
      err_count++;
    end
    $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
             table_q.size(), table_q.size() - fail_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== design/clint_top.sv ====
// CLINT subsystem top level wiring the command, response and interrupt ports to the slice
`timescale 1ns/1ps

module clint_top
  (
    input  logic                                clk_i,
    input  logic                                rt_clk_i,
    input  logic                                rst_n_i,

    input  clint_pkg::mem_header_s              mem_cmd_header_i,
    input  logic [clint_pkg::dword_width-1:0]   mem_cmd_data_i,
    input  logic                                mem_cmd_v_i,
    output logic                                mem_cmd_ready_and_o,

    output clint_pkg::mem_header_s              mem_resp_header_o,
    output logic [clint_pkg::dword_width-1:0]   mem_resp_data_o,
    output logic                                mem_resp_v_o,
    input  logic                                mem_resp_ready_and_i,

    output logic                                software_irq_o,
    output logic                                timer_irq_o,
    output logic                                m_external_irq_o,
    output logic                                s_external_irq_o
  );

  clint_slice u_slice
    (
      .clk_i                (clk_i),
      .rt_clk_i             (rt_clk_i),
      .rst_n_i              (rst_n_i),
      .mem_cmd_header_i     (mem_cmd_header_i),
      .mem_cmd_data_i       (mem_cmd_data_i),
      .mem_cmd_v_i          (mem_cmd_v_i),
      .mem_cmd_ready_and_o  (mem_cmd_ready_and_o),
      .mem_resp_header_o    (mem_resp_header_o),
      .mem_resp_data_o      (mem_resp_data_o),
      .mem_resp_v_o         (mem_resp_v_o),
      .mem_resp_ready_and_i (mem_resp_ready_and_i),
      .software_irq_o       (software_irq_o),
      .timer_irq_o          (timer_irq_o),
      .m_external_irq_o     (m_external_irq_o),
      .s_external_irq_o     (s_external_irq_o)
    );

endmodule

// ==== design/clint_slice.sv ====
// CLINT slice with the device registers, timer compare, interrupt outputs and read data mux
`timescale 1ns/1ps

module clint_slice
  (
    input  logic                                clk_i,
    input  logic                                rt_clk_i,
    input  logic                                rst_n_i,

    input  clint_pkg::mem_header_s              mem_cmd_header_i,
    input  logic [clint_pkg::dword_width-1:0]   mem_cmd_data_i,
    input  logic                                mem_cmd_v_i,
    output logic                                mem_cmd_ready_and_o,

    output clint_pkg::mem_header_s              mem_resp_header_o,
    output logic [clint_pkg::dword_width-1:0]   mem_resp_data_o,
    output logic                                mem_resp_v_o,
    input  logic                                mem_resp_ready_and_i,

    // Local interrupts
    output logic                                software_irq_o,
    output logic                                timer_irq_o,
    output logic                                m_external_irq_o,
    output logic                                s_external_irq_o
  );

  logic [clint_pkg::num_regs-1:0]             w_v;
  clint_pkg::reg_sel_e                        rd_sel;
  logic [clint_pkg::dev_addr_width-1:0]       addr;
  logic [clint_pkg::dword_width-1:0]          wdata;
  logic [clint_pkg::dword_width-1:0]          rd_data;
  logic [clint_pkg::dword_width-1:0]          mtime;
  logic                                       msip_r;
  logic [clint_pkg::dword_width-1:0]          mtimecmp_r;
  logic [1:0]                                 mtimesel_r;
  logic [clint_pkg::plic_els-1:0]             plic_r;
  logic [clint_pkg::plic_idx_width-1:0]       plic_idx;

  clint_reg_port u_port
    (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .mem_cmd_header_i     (mem_cmd_header_i),
      .mem_cmd_data_i       (mem_cmd_data_i),
      .mem_cmd_v_i          (mem_cmd_v_i),
      .mem_cmd_ready_and_o  (mem_cmd_ready_and_o),
      .mem_resp_header_o    (mem_resp_header_o),
      .mem_resp_data_o      (mem_resp_data_o),
      .mem_resp_v_o         (mem_resp_v_o),
      .mem_resp_ready_and_i (mem_resp_ready_and_i),
      .w_v_o                (w_v),
      .rd_sel_o             (rd_sel),
      .addr_o               (addr),
      .data_o               (wdata),
      .rd_data_i            (rd_data)
    );

  clint_mtime u_mtime
    (
      .clk_i    (clk_i),
      .rt_clk_i (rt_clk_i),
      .rst_n_i  (rst_n_i),
      .sel_i    (mtimesel_r),
      .mtime_o  (mtime)
    );

  assign plic_idx = addr[2 +: clint_pkg::plic_idx_width];

  // The mtime strobe has no register behind it, so mtime writes are dropped
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      msip_r     <= 1'b0;
      mtimecmp_r <= '0;
      mtimesel_r <= 2'd0;
      plic_r     <= '0;
    end
    else
    begin
      if (w_v[clint_pkg::e_reg_msip])
        msip_r <= wdata[0];
      if (w_v[clint_pkg::e_reg_mtimecmp])
        mtimecmp_r <= wdata;
      if (w_v[clint_pkg::e_reg_mtimesel])
        mtimesel_r <= wdata[1:0];
      if (w_v[clint_pkg::e_reg_plic])
        plic_r[plic_idx] <= wdata[0];
    end
  end

  always_comb
  begin
    case (rd_sel)
      clint_pkg::e_reg_msip:     rd_data = {{(clint_pkg::dword_width-1){1'b0}}, msip_r};
      clint_pkg::e_reg_mtimecmp: rd_data = mtimecmp_r;
      clint_pkg::e_reg_mtimesel: rd_data = {{(clint_pkg::dword_width-2){1'b0}}, mtimesel_r};
      clint_pkg::e_reg_mtime:    rd_data = mtime;
      clint_pkg::e_reg_plic:     rd_data = {{(clint_pkg::dword_width-1){1'b0}}, plic_r[plic_idx]};
      default:                   rd_data = '0;
    endcase
  end

  assign software_irq_o   = msip_r;
  assign timer_irq_o      = (mtime >= mtimecmp_r);
  assign m_external_irq_o = plic_r[0];
  assign s_external_irq_o = plic_r[1];

  // The port decodes one register per command
  property p_plic_alone;
    @(posedge clk_i) disable iff (!rst_n_i)
      w_v[clint_pkg::e_reg_plic] |-> $onehot(w_v);
  endproperty

  a_plic_alone: assert property (p_plic_alone)
    else $error("clint_slice: plic strobe fired with another strobe");

endmodule

// ==== design/clint_mtime.sv ====
// Real-time counter with clock divider, source select, Gray counter, synchronizer and Gray decode
`timescale 1ns/1ps

module clint_mtime
  (
    input  logic                                clk_i,
    input  logic                                rt_clk_i,
    input  logic                                rst_n_i,
    input  logic [1:0]                          sel_i,
    output logic [clint_pkg::dword_width-1:0]   mtime_o
  );

  logic [2:0]                           div_cnt_r;
  logic [2:0]                           div_cnt_n;
  logic                                 clk_div_r;
  logic                                 tmr_clk;
  logic [clint_pkg::dword_width-1:0]    bin_r;
  logic [clint_pkg::dword_width-1:0]    bin_n;
  logic [clint_pkg::dword_width-1:0]    gray_r;
  logic [clint_pkg::dword_width-1:0]    gray_meta_r;
  logic [clint_pkg::dword_width-1:0]    gray_sync_r;

  // The top counter bit flips every fourth clk_i edge and divides clk_i by 8
  assign div_cnt_n = div_cnt_r + 3'd1;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      div_cnt_r <= 3'd0;
      clk_div_r <= 1'b0;
    end
    else
    begin
      div_cnt_r <= div_cnt_n;
      clk_div_r <= div_cnt_n[2];
    end
  end

  // Select 3 stops the timer clock
  always_comb
  begin
    case (sel_i)
      2'd0:    tmr_clk = clk_i;
      2'd1:    tmr_clk = clk_div_r;
      2'd2:    tmr_clk = rt_clk_i;
      default: tmr_clk = 1'b0;
    endcase
  end

  assign bin_n = bin_r + 1'b1;

  // The Gray copy is registered in the timer domain so only one bit moves per tick
  always_ff @(posedge tmr_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bin_r  <= '0;
      gray_r <= '0;
    end
    else
    begin
      bin_r  <= bin_n;
      gray_r <= bin_n ^ (bin_n >> 1);
    end
  end

  // Two flop synchronizer into clk_i
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      gray_meta_r <= '0;
      gray_sync_r <= '0;
    end
    else
    begin
      gray_meta_r <= gray_r;
      gray_sync_r <= gray_meta_r;
    end
  end

  // Each binary bit is the XOR of all Gray bits at and above it
  always_comb
  begin
    mtime_o[clint_pkg::dword_width-1] = gray_sync_r[clint_pkg::dword_width-1];
    for (int i = clint_pkg::dword_width - 2; i >= 0; i--)
      mtime_o[i] = mtime_o[i+1] ^ gray_sync_r[i];
  end

  // Holds as long as the timer clock is no faster than clk_i
  property p_gray_step;
    @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gray_sync_r ^ $past(gray_sync_r));
  endproperty

  a_gray_step: assert property (p_gray_step)
    else $error("clint_mtime: synchronized Gray value moved by more than one bit");

endmodule

// ==== design/clint_reg_port.sv ====
// Command port with address decode, write strobes, read select and a one-entry response register
`timescale 1ns/1ps

module clint_reg_port
  (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,

    // Command channel
    input  clint_pkg::mem_header_s                     mem_cmd_header_i,
    input  logic [clint_pkg::dword_width-1:0]          mem_cmd_data_i,
    input  logic                                       mem_cmd_v_i,
    output logic                                       mem_cmd_ready_and_o,

    // Response channel
    output clint_pkg::mem_header_s                     mem_resp_header_o,
    output logic [clint_pkg::dword_width-1:0]          mem_resp_data_o,
    output logic                                       mem_resp_v_o,
    input  logic                                       mem_resp_ready_and_i,

    // Register side
    output logic [clint_pkg::num_regs-1:0]             w_v_o,
    output clint_pkg::reg_sel_e                        rd_sel_o,
    output logic [clint_pkg::dev_addr_width-1:0]       addr_o,
    output logic [clint_pkg::dword_width-1:0]          data_o,
    input  logic [clint_pkg::dword_width-1:0]          rd_data_i
  );

  logic                                 cmd_xfer;
  logic                                 is_write;
  logic                                 is_read;
  logic                                 hit;
  logic                                 plic_hit;
  logic                                 resp_v_r;
  clint_pkg::mem_header_s               resp_header_r;
  logic [clint_pkg::dword_width-1:0]    resp_data_r;

  assign addr_o = mem_cmd_header_i.addr;
  assign data_o = mem_cmd_data_i;

  assign is_write = (mem_cmd_header_i.msg_type == clint_pkg::e_mem_wr);
  assign is_read  = (mem_cmd_header_i.msg_type == clint_pkg::e_mem_rd);

  // Only one command may be outstanding, so a held response blocks the port
  assign mem_cmd_ready_and_o = ~resp_v_r;
  assign cmd_xfer            = mem_cmd_v_i & mem_cmd_ready_and_o;

  // The plic range ignores the index bits above bit 1
  assign plic_hit =
    (addr_o[clint_pkg::dev_addr_width-1:2+clint_pkg::plic_idx_width]
      == clint_pkg::plic_addr[clint_pkg::dev_addr_width-1:2+clint_pkg::plic_idx_width])
    && (addr_o[1:0] == clint_pkg::plic_addr[1:0]);

  always_comb
  begin
    hit      = 1'b1;
    rd_sel_o = clint_pkg::e_reg_msip;
    if (addr_o == clint_pkg::msip_addr)
      rd_sel_o = clint_pkg::e_reg_msip;
    else if (addr_o == clint_pkg::mtimecmp_addr)
      rd_sel_o = clint_pkg::e_reg_mtimecmp;
    else if (addr_o == clint_pkg::mtimesel_addr)
      rd_sel_o = clint_pkg::e_reg_mtimesel;
    else if (addr_o == clint_pkg::mtime_addr)
      rd_sel_o = clint_pkg::e_reg_mtime;
    else if (plic_hit)
      rd_sel_o = clint_pkg::e_reg_plic;
    else
      hit = 1'b0;
  end

  // One strobe per accepted write to a mapped register
  always_comb
  begin
    w_v_o = '0;
    if (cmd_xfer && is_write && hit)
      w_v_o[rd_sel_o] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_xfer)
      resp_v_r <= 1'b1;
    else if (mem_resp_ready_and_i)
      resp_v_r <= 1'b0;
  end

  // Read data is captured at the transfer edge and writes answer with zero
  always_ff @(posedge clk_i)
  begin
    if (cmd_xfer)
    begin
      resp_header_r <= mem_cmd_header_i;
      resp_data_r   <= (is_read && hit) ? rd_data_i : '0;
    end
  end

  assign mem_resp_v_o      = resp_v_r;
  assign mem_resp_header_o = resp_header_r;
  assign mem_resp_data_o   = resp_data_r;

  // A stalled response keeps its contents until the sink takes it
  property p_resp_hold;
    @(posedge clk_i) disable iff (!rst_n_i)
      (mem_resp_v_o && !mem_resp_ready_and_i)
        |=> (mem_resp_v_o && $stable(mem_resp_header_o) && $stable(mem_resp_data_o));
  endproperty

  a_resp_hold: assert property (p_resp_hold)
    else $error("clint_reg_port: response changed while stalled");

endmodule

// ==== design/clint_pkg.sv ====
// CLINT package with widths, device address map, message opcodes, command header and register index
package clint_pkg;

  // Data path and device address widths
  localparam int dword_width    = 64;
  localparam int dev_addr_width = 16;

  // Device address map relative to the CLINT base
  localparam logic [dev_addr_width-1:0] msip_addr     = 16'h0000;
  localparam logic [dev_addr_width-1:0] mtimecmp_addr = 16'h4000;
  localparam logic [dev_addr_width-1:0] mtimesel_addr = 16'h8000;

  // External interrupt bits start here
  // Address bit 2 selects machine (0) or supervisor (1)
  localparam logic [dev_addr_width-1:0] plic_addr     = 16'hB000;

  // Read-only real-time counter
  localparam logic [dev_addr_width-1:0] mtime_addr    = 16'hBFF8;

  // Number of external interrupt bits and the address bits that index them
  localparam int plic_els       = 2;
  localparam int plic_idx_width = $clog2(plic_els);

  // Decoded register groups behind the command port
  localparam int num_regs = 5;

  // Message type of a single-beat command
  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_op_e;

  // The command header is echoed unchanged as the response header
  // Size is log2 of the byte count and is not used for masking
  typedef struct packed
  {
    mem_op_e                   msg_type;
    logic [2:0]                size;
    logic [dev_addr_width-1:0] addr;
  } mem_header_s;

  // The register group index is also the bit position of each write strobe
  typedef enum logic [2:0]
  {
    e_reg_msip     = 3'd0,
    e_reg_mtimecmp = 3'd1,
    e_reg_mtimesel = 3'd2,
    e_reg_mtime    = 3'd3,
    e_reg_plic     = 3'd4
  } reg_sel_e;

endpackage
